/* sim.f */
fetch_pkg.sv
pc_gen.sv
btb.sv
inst_mem.sv
fetch_stage.sv
fetch_queue.sv
fetch_top.sv
tb_fetch.sv

/* Makefile */
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* tb_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_fetch
  import fetch_pkg::*;
();

  // roughly five times the load plus the tests
  localparam int TIMEOUT_CYCLES = 2000;

  logic         clk;
  logic         rst;
  mem_load_t    load_i;
  redirect_t    trap_i;
  redirect_t    branch_i;
  btb_update_t  btb_update_i;
  logic         fetch_ready_i;
  fetch_entry_t fetch_o;
  logic         fetch_valid_o;

  logic [15:0]     image [IMEM_HW_DEPTH]; // program as loaded
  logic [XLEN-1:0] exp_pc;                // model pc of next expected entry
  integer          seed;
  int              cycle_count;
  int              err_count;
  int              check_count;
  int              test_count;
  int              n_comp;                // lengths seen at fetch_o
  int              n_full;

  fetch_top uut (
    .clk           (clk),
    .rst           (rst),
    .load_i        (load_i),
    .trap_i        (trap_i),
    .branch_i      (branch_i),
    .btb_update_i  (btb_update_i),
    .fetch_o       (fetch_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i)
  );

  always #2 clk = ~clk; // 4 ns period

  // run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: fetch stream stuck after %0d cycles", cycle_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // whole halfword index appears in the data
  // low bits mix 16 and 32 bit lengths
  function automatic logic [15:0] fill_hw(input logic [7:0] i);
    return {i, ~i[5:0], i[1:0] ^ i[4:3]};
  endfunction

  // expected entry at pc from the loaded image
  function automatic fetch_entry_t model_entry(input logic [XLEN-1:0] pc, input logic taken);
    fetch_entry_t e;
    logic [7:0]   idx;
    logic [15:0]  lo;
    logic [15:0]  hi;
    idx = pc[8:1];              // wraps at 256 halfwords
    lo  = image[idx];
    hi  = image[idx + 8'd1];
    e.pc            = pc;
    e.is_compressed = (lo[1:0] != 2'b11); // rvc unless bits 1:0 are 2'b11
    e.inst          = e.is_compressed ? {16'h0000, lo} : {hi, lo};
    e.pred_taken    = taken;
    return e;
  endfunction

  function automatic logic [XLEN-1:0] seq_pc(input logic [XLEN-1:0] pc);
    logic [15:0] lo;
    lo = image[pc[8:1]];
    return pc + ((lo[1:0] != 2'b11) ? 32'd2 : 32'd4);
  endfunction

  task automatic check_entry(input string name, input fetch_entry_t got,
                             input fetch_entry_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_pc(input string name, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
    end
  endtask

  // whole memory one halfword per cycle
  task automatic load_program();
    for (int i = 0; i < IMEM_HW_DEPTH; i++) begin
      @(negedge clk);
      load_i.valid = 1'b1;
      load_i.addr  = i * 2;
      load_i.data  = image[i];
    end
    @(negedge clk);
    load_i = '0;
  endtask

  // takes one entry and checks it holds still while ready is low
  task automatic pop_entry(input bit rand_ready, output fetch_entry_t got);
    fetch_entry_t held;
    logic [31:0]  ready_bits;
    bit           have_held;
    bit           taken;
    have_held = 1'b0;
    taken     = 1'b0;
    while (!taken) begin
      @(negedge clk);
      ready_bits    = $random(seed);
      fetch_ready_i = rand_ready ? ready_bits[0] : 1'b1;
      if (fetch_valid_o) begin
        if (have_held) check_entry("fetch_o held", fetch_o, held);
        if (fetch_ready_i) begin
          got   = fetch_o;   // moves at the coming edge
          taken = 1'b1;
        end else begin
          held      = fetch_o;
          have_held = 1'b1;
        end
      end else if (have_held) begin
        err_count++;
        $display("fetch_valid_o dropped before pc %h was taken", held.pc);
        have_held = 1'b0;
      end
    end
    @(posedge clk);
  endtask

  task automatic expect_next(input bit rand_ready, input bit taken);
    fetch_entry_t got;
    fetch_entry_t exp;
    exp = model_entry(exp_pc, taken);
    pop_entry(rand_ready, got);
    check_entry("fetch_o", got, exp);
    if (got.is_compressed) n_comp++;
    else n_full++;
    exp_pc = seq_pc(exp_pc);
  endtask

  // first entry of a new stream with its pc checked apart
  task automatic expect_head();
    fetch_entry_t got;
    fetch_entry_t exp;
    exp = model_entry(exp_pc, 1'b0);
    pop_entry(1'b0, got);
    check_pc("fetch_o.pc", got.pc, exp_pc);
    check_entry("fetch_o", got, exp);
    exp_pc = seq_pc(exp_pc);
  endtask

  // one cycle redirect pulse then the queue is empty
  task automatic drive_redirect(input logic trap_v, input logic [XLEN-1:0] trap_t,
                                input logic br_v, input logic [XLEN-1:0] br_t);
    @(negedge clk);
    fetch_ready_i   = 1'b0;
    trap_i.valid    = trap_v;
    trap_i.target   = trap_t;
    branch_i.valid  = br_v;
    branch_i.target = br_t;
    @(negedge clk);
    trap_i   = '0;
    branch_i = '0;
    check_flag("fetch_valid_o", fetch_valid_o, 1'b0);
    exp_pc = trap_v ? trap_t : br_t;
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) $display("test %-16s ok", name);
    else $display("test %-16s %0d mismatches", name, err_count - errs_before);
  endtask

  task automatic test_reset_seq();
    int errs;
    errs = err_count;
    @(negedge clk);
    rst = 1'b0;
    check_flag("fetch_valid_o", fetch_valid_o, 1'b0); // still reset state
    check_pc("cur_pc", uut.cur_pc, RESET_PC);
    exp_pc = RESET_PC;
    n_comp = 0;
    n_full = 0;
    repeat (12) expect_next(1'b0, 1'b0);
    if (n_comp == 0 || n_full == 0) begin
      err_count++;
      $display("sequential stream did not mix 16 and 32 bit instructions");
    end
    report_test("reset_seq", errs);
  endtask

  task automatic test_backpressure();
    int errs;
    errs = err_count;
    // let the queue fill up
    do begin
      @(negedge clk);
      fetch_ready_i = 1'b0;
    end while (!uut.q_full);
    repeat (16) expect_next(1'b1, 1'b0); // stream continues from test 1
    report_test("backpressure", errs);
  endtask

  task automatic test_branch();
    int errs;
    errs = err_count;
    drive_redirect(1'b0, '0, 1'b1, 32'h0000_0106);
    expect_head();
    repeat (7) expect_next(1'b0, 1'b0);
    report_test("branch", errs);
  endtask

  task automatic test_priority();
    int errs;
    errs = err_count;
    drive_redirect(1'b1, 32'h0000_01a0, 1'b1, 32'h0000_0080); // trap wins
    expect_head();
    repeat (5) expect_next(1'b0, 1'b0);
    report_test("priority", errs);
  endtask

  task automatic test_btb();
    int              errs;
    logic [XLEN-1:0] start;
    logic [XLEN-1:0] br_pc;
    logic [XLEN-1:0] tgt;
    errs  = err_count;
    start = 32'h0000_0040;
    tgt   = 32'h0000_00c2;
    br_pc = seq_pc(seq_pc(seq_pc(start))); // third instruction after start
    @(negedge clk);
    fetch_ready_i       = 1'b0;
    btb_update_i.valid  = 1'b1;
    btb_update_i.pc     = br_pc;
    btb_update_i.target = tgt;
    @(negedge clk);
    btb_update_i = '0;
    drive_redirect(1'b0, '0, 1'b1, start);
    repeat (3) expect_next(1'b0, 1'b0); // untrained pcs
    expect_next(1'b0, 1'b1);            // predicted taken
    exp_pc = tgt;
    expect_head();
    repeat (3) expect_next(1'b0, 1'b0);
    report_test("btb", errs);
  endtask

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    load_i        = '0;
    trap_i        = '0;
    branch_i      = '0;
    btb_update_i  = '0;
    fetch_ready_i = 1'b0;
    seed          = 34;
    cycle_count   = 0;
    err_count     = 0;
    check_count   = 0;
    test_count    = 0;
    exp_pc        = RESET_PC;
    for (int i = 0; i < IMEM_HW_DEPTH; i++) image[i] = fill_hw(i[7:0]);
    load_program();              // under reset
    repeat (8) @(negedge clk);   // reset cycles once loaded
    test_reset_seq();
    test_backpressure();
    test_branch();
    test_priority();
    test_btb();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top
  import fetch_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  input  mem_load_t    load_i,        // program load
  input  redirect_t    trap_i,
  input  redirect_t    branch_i,
  input  btb_update_t  btb_update_i,
  output fetch_entry_t fetch_o,       // to decode
  output logic         fetch_valid_o,
  input  wire          fetch_ready_i
);

  logic [XLEN-1:0] fetch_addr;  // pre-if address
  logic [XLEN-1:0] cur_pc;
  inst_word_u      rdata;
  logic            bpu_hit;
  logic [XLEN-1:0] bpu_target;
  logic            advance;
  logic            is_compressed;
  logic            kill;
  logic            push;
  logic            q_full;
  fetch_entry_t    entry;

  // any redirect flushes the front end
  assign kill = trap_i.valid | branch_i.valid;

  pc_gen u_pc_gen (
    .clk             (clk),
    .rst             (rst),
    .trap_i          (trap_i),
    .branch_i        (branch_i),
    .bpu_hit_i       (bpu_hit & advance), // only follow btb for accepted words
    .bpu_target_i    (bpu_target),
    .advance_i       (advance),
    .is_compressed_i (is_compressed),
    .fetch_addr_o    (fetch_addr),
    .cur_pc_o        (cur_pc)
  );

  btb u_btb (
    .clk         (clk),
    .rst         (rst),
    .lookup_pc_i (cur_pc),
    .update_i    (btb_update_i),
    .hit_o       (bpu_hit),
    .target_o    (bpu_target)
  );

  inst_mem u_inst_mem (
    .clk     (clk),
    .load_i  (load_i),
    .addr_i  (fetch_addr),
    .rdata_o (rdata)
  );

  fetch_stage u_fetch_stage (
    .clk             (clk),
    .rst             (rst),
    .kill_i          (kill),
    .cur_pc_i        (cur_pc),
    .rdata_i         (rdata),
    .bpu_hit_i       (bpu_hit),
    .q_full_i        (q_full),
    .push_o          (push),
    .entry_o         (entry),
    .advance_o       (advance),
    .is_compressed_o (is_compressed)
  );

  fetch_queue u_fetch_queue (
    .clk     (clk),
    .rst     (rst),
    .flush_i (kill),
    .push_i  (push),
    .entry_i (entry),
    .full_o  (q_full),
    .valid_o (fetch_valid_o),
    .entry_o (fetch_o),
    .ready_i (fetch_ready_i)
  );

endmodule

`default_nettype wire

/* fetch_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_queue
  import fetch_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  input  wire          flush_i,   // redirect, drop everything
  input  wire          push_i,
  input  fetch_entry_t entry_i,
  output logic         full_o,
  output logic         valid_o,   // head entry to decode
  output fetch_entry_t entry_o,
  input  wire          ready_i
);

  fetch_entry_t buf_q [FQ_DEPTH]; // entry storage

  logic [FQ_AW-1:0] wr_ptr_q;
  logic [FQ_AW-1:0] rd_ptr_q;
  logic [FQ_AW:0]   count_q;  // one extra bit for full
  logic             pop;
  logic             do_push;

  assign full_o  = (count_q == FQ_DEPTH[FQ_AW:0]);
  assign valid_o = (count_q != '0);
  assign entry_o = buf_q[rd_ptr_q];

  assign pop     = valid_o && ready_i;
  assign do_push = push_i && !full_o; // stage already checks full

  // pointers and count
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0; // flush wins over push and pop
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1; // depth is a power of two
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or neither
      endcase
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (do_push) begin
      buf_q[wr_ptr_q] <= entry_i;
    end
  end

  // fetch_stage must see full before pushing
  a_no_push_full : assert property (
    @(posedge clk) disable iff (rst)
    push_i |-> !full_o
  ) else $error("fetch_queue: push while full");

  // decode side handshake, head held until taken
  a_out_stable : assert property (
    @(posedge clk) disable iff (rst)
    (valid_o && !ready_i && !flush_i) |=> (valid_o && $stable(entry_o))
  ) else $error("fetch_queue: head entry changed while stalled");

endmodule

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
  import fetch_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  input  wire             kill_i,          // trap or branch redirect
  input  wire  [XLEN-1:0] cur_pc_i,
  input  inst_word_u      rdata_i,         // imem word for cur_pc
  input  wire             bpu_hit_i,       // raw btb hit for cur_pc
  input  wire             q_full_i,
  output logic            push_o,
  output fetch_entry_t    entry_o,
  output logic            advance_o,       // lets pc_gen step
  output logic            is_compressed_o
);

  logic word_vld_q; // imem word matches cur_pc
  logic is_c;

  // no word is in flight in the cycle after reset or a kill
  always_ff @(posedge clk) begin
    if (rst) begin
      word_vld_q <= 1'b0;
    end else if (kill_i) begin
      word_vld_q <= 1'b0; // drop wrong-path word
    end else begin
      word_vld_q <= 1'b1;
    end
  end

  // length from the quadrant bits
  assign is_c = (rdata_i.comp.c_inst.quadrant != 2'b11);

  // accept when valid, room in queue and not being redirected
  assign push_o          = word_vld_q && !q_full_i && !kill_i;
  assign advance_o       = push_o; // btb target only taken with this
  assign is_compressed_o = is_c;

  always_comb begin
    entry_o.pc = cur_pc_i;
    if (is_c) begin
      entry_o.inst = {16'h0000, rdata_i.comp.c_inst}; // next parcel not part of it
    end else begin
      entry_o.inst = rdata_i;
    end
    entry_o.is_compressed = is_c;
    entry_o.pred_taken    = bpu_hit_i;
  end

endmodule

`default_nettype wire

/* inst_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_mem
  import fetch_pkg::*;
(
  input  wire             clk,
  input  mem_load_t       load_i,  // program load port
  input  wire  [XLEN-1:0] addr_i,  // pre-if fetch address
  output inst_word_u      rdata_o  // word at last cycle's addr_i
);

  logic [15:0] mem_q [IMEM_HW_DEPTH]; // halfword array

  logic [IMEM_AW-1:0] rd_idx_lo;
  logic [IMEM_AW-1:0] rd_idx_hi;
  logic [IMEM_AW-1:0] wr_idx;

  // byte address to halfword index, upper bits wrap
  assign rd_idx_lo = addr_i[IMEM_AW:1];
  assign rd_idx_hi = rd_idx_lo + 1'b1; // wraps at depth
  assign wr_idx    = load_i.addr[IMEM_AW:1];

  // load port
  always_ff @(posedge clk) begin
    if (load_i.valid) begin
      mem_q[wr_idx] <= load_i.data;
    end
  end

  // sync read of two parcels, lower address in [15:0]
  // a 32 bit insn may straddle any halfword boundary
  always_ff @(posedge clk) begin
    rdata_o <= {mem_q[rd_idx_hi], mem_q[rd_idx_lo]};
  end

endmodule

`default_nettype wire

/* btb.sv */
`timescale 1ns/1ns
`default_nettype none

module btb
  import fetch_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  input  wire  [XLEN-1:0] lookup_pc_i, // current pc
  input  btb_update_t     update_i,    // training from outside
  output logic            hit_o,
  output logic [XLEN-1:0] target_o
);

  // direct mapped storage
  logic [BTB_ENTRIES-1:0] valid_q;
  logic [BTB_TAG_W-1:0]   tag_q    [BTB_ENTRIES];
  logic [XLEN-1:0]        target_q [BTB_ENTRIES];

  // lookup side
  logic [BTB_IDX_W-1:0] lk_idx;
  logic [BTB_TAG_W-1:0] lk_tag;

  // update side
  logic [BTB_IDX_W-1:0] up_idx;
  logic [BTB_TAG_W-1:0] up_tag;

  // pc[0] is always zero, index starts at bit 1
  assign lk_idx = lookup_pc_i[BTB_IDX_W:1];
  assign lk_tag = lookup_pc_i[XLEN-1:BTB_IDX_W+1];

  assign up_idx = update_i.pc[BTB_IDX_W:1];
  assign up_tag = update_i.pc[XLEN-1:BTB_IDX_W+1];

  // valid bits only, cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (update_i.valid) begin
      valid_q[up_idx] <= 1'b1;
    end
  end

  // tag and target payload
  always_ff @(posedge clk) begin
    if (update_i.valid) begin
      tag_q[up_idx]    <= up_tag;     // overwrite, no replacement policy
      target_q[up_idx] <= update_i.target;
    end
  end

  // combinational lookup, new entries seen from the cycle after the write
  always_comb begin
    hit_o    = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    target_o = target_q[lk_idx];
  end

  // trainer must hand in real instruction addresses
  a_update_aligned : assert property (
    @(posedge clk) disable iff (rst)
    update_i.valid |-> (update_i.pc[0] == 1'b0 && update_i.target[0] == 1'b0)
  ) else $error("btb: misaligned update pc %h target %h",
                update_i.pc, update_i.target);

endmodule

`default_nettype wire

/* pc_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module pc_gen
  import fetch_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  input  redirect_t       trap_i,          // highest priority
  input  redirect_t       branch_i,        // from execute
  input  wire             bpu_hit_i,       // already gated with advance
  input  wire  [XLEN-1:0] bpu_target_i,
  input  wire             advance_i,       // current word accepted
  input  wire             is_compressed_i, // length of current word
  output logic [XLEN-1:0] fetch_addr_o,    // pre-if address to imem
  output logic [XLEN-1:0] cur_pc_o
);

  logic [XLEN-1:0] pc_q;    // pc of word coming back from imem
  logic [XLEN-1:0] pc_seq;  // fall-through
  logic [XLEN-1:0] pc_next;

  // 2 bytes for rvc, 4 otherwise
  assign pc_seq = pc_q + (is_compressed_i ? 32'd2 : 32'd4);

  // trap > branch > hold > btb > sequential
  always_comb begin
    if (trap_i.valid) begin
      pc_next = trap_i.target;
    end else if (branch_i.valid) begin
      pc_next = branch_i.target;
    end else if (!advance_i) begin
      // stall, re-read the same word
      pc_next = pc_q;
    end else if (bpu_hit_i) begin
      pc_next = bpu_target_i;
    end else begin
      pc_next = pc_seq;
    end
  end

  // redirects load even while stalled, hold case is folded into pc_next
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign fetch_addr_o = pc_next; // imem returns this word next cycle
  assign cur_pc_o     = pc_q;

  // targets come from execute, trap unit and btb, all must stay halfword aligned
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (rst)
    pc_q[0] == 1'b0
  ) else $error("pc_gen: misaligned pc %h", pc_q);

endmodule

`default_nettype wire

/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // datapath width
  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000; // boot vector

  // instruction memory, halfword granular
  localparam int IMEM_HW_DEPTH = 256;
  localparam int IMEM_AW = $clog2(IMEM_HW_DEPTH); // halfword index width

  // btb geometry, index from pc[4:1]
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_W = XLEN - BTB_IDX_W - 1; // pc bits above the index

  // fetch queue
  localparam int FQ_DEPTH = 4;
  localparam int FQ_AW = $clog2(FQ_DEPTH);

  // trap or branch redirect
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
  } redirect_t;

  // btb training write
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;     // branch pc
    logic [XLEN-1:0] target; // taken target
  } btb_update_t;

  // program load, one halfword per beat
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr; // byte address
    logic [15:0]     data;
  } mem_load_t;

  // 32 bit encoding
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode; // [1:0] == 2'b11 for full length
  } inst_full_t;

  // rvc parcel
  typedef struct packed {
    logic [13:0] body;
    logic [1:0]  quadrant; // 2'b11 never valid here
  } c_inst_t;

  typedef struct packed {
    logic [15:0] upper; // next parcel, ignored for rvc
    c_inst_t     c_inst;
  } inst_comp_t;

  // one fetched word, two views
  typedef union packed {
    inst_full_t full;
    inst_comp_t comp;
  } inst_word_u;

  // entry handed to decode
  typedef struct packed {
    logic [XLEN-1:0] pc;
    inst_word_u      inst;
    logic            is_compressed;
    logic            pred_taken; // btb said taken at this pc
  } fetch_entry_t;

endpackage

`default_nettype wire
